// File: fm_mmr_pkg.sv
/*
 * FM register block shared definitions
 * Widths, global register numbers and the structs that link the stages
 */

package fm_mmr_pkg;

    typedef logic [7:0] reg_addr_t;   // Register number
    typedef logic [7:0] reg_data_t;   // Host data byte
    typedef logic [9:0] timer_a_t;
    typedef logic [7:0] timer_b_t;
    typedef logic [8:0] pcm_t;        // DAC sample
    typedef logic [2:0] ch_t;         // Part, then register bits 1:0
    typedef logic [1:0] op_t;         // 0=S1 1=S3 2=S2 3=S4

    // Global register map
    localparam reg_addr_t reg_testym  = 8'h21;
    localparam reg_addr_t reg_lfo     = 8'h22;
    localparam reg_addr_t reg_clka1   = 8'h24;
    localparam reg_addr_t reg_clka2   = 8'h25;
    localparam reg_addr_t reg_clkb    = 8'h26;
    localparam reg_addr_t reg_timer   = 8'h27;
    localparam reg_addr_t reg_kon     = 8'h28;
    localparam reg_addr_t reg_pcm     = 8'h2A;
    localparam reg_addr_t reg_pcm_en  = 8'h2B;
    localparam reg_addr_t reg_dactest = 8'h2C;

    // One host data write as seen by the execute and result stages
    typedef struct packed {
        logic      strobe;   // Data write in this cycle
        reg_addr_t sel_reg;  // Latched register number
        logic      part;
        reg_data_t data;
    } data_wr_t;

    typedef struct packed {
        timer_a_t value_a;
        timer_b_t value_b;
        logic     load_a;
        logic     load_b;
        logic     enable_irq_a;
        logic     enable_irq_b;
        logic     clr_flag_a;    // One shot
        logic     clr_flag_b;    // One shot
    } timer_cfg_t;

    typedef struct packed {
        logic       csm;
        logic       effect;
        logic       lfo_en;
        logic [2:0] lfo_freq;
        logic       eg_stop;
        logic       pg_stop;
        logic       fast_timers;
    } chip_mode_t;

    typedef struct packed {
        pcm_t sample;
        logic en;
        logic wr;      // One shot
    } pcm_out_t;

    // Update selects for the external channel register file
    typedef struct packed {
        logic       keyon;
        ch_t        ch;
        op_t        op;
        logic [2:0] chreg;   // fnum-low, algorithm, pms
        logic [6:0] opreg;   // dt1, tl, ks_ar, amen_dr, sr, sl_rr, ssgeg
        reg_data_t  data;
    } reg_update_t;

endpackage

// File: fm_write_decode.sv
/*
 * FM register block write decode
 * Latches the register number on address writes, qualifies data writes
 * and runs the busy flag for a fixed number of clock-enable pulses
 */

`timescale 1ns/100ps

module fm_write_decode #(
    parameter int busy_len = 32
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cen,
    input  fm_mmr_pkg::reg_data_t din,
    input  logic                  write,
    input  logic [1:0]            addr,
    output fm_mmr_pkg::data_wr_t  wr,
    output logic                  busy
);

    // Counter holds 0 .. busy_len-1
    localparam int cnt_w = (busy_len > 1) ? $clog2(busy_len) : 1;
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(busy_len - 1);

    fm_mmr_pkg::reg_addr_t sel_reg;
    logic                  part;
    logic                  data_wr;
    logic                  data_wr_q;    // Previous qualified write level
    logic                  data_wr_rise;
    logic [cnt_w-1:0]      busy_cnt;

    assign data_wr      = write && addr[0];
    assign data_wr_rise = data_wr && !data_wr_q;

    // Address phase
    always_ff @(posedge clk) begin
        if (rst) begin
            sel_reg <= '0;
            part    <= 1'b0;
        end else if (write && !addr[0]) begin
            sel_reg <= din;
            part    <= addr[1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            data_wr_q <= 1'b0;
        end else begin
            data_wr_q <= data_wr;
        end
    end

    // Busy restarts on every new data write
    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            busy_cnt <= '0;
        end else if (data_wr_rise) begin
            busy     <= 1'b1;
            busy_cnt <= '0;
        end else if (cen && busy) begin
            if (busy_cnt == cnt_last) begin
                busy     <= 1'b0;   // busy_len-th pulse
                busy_cnt <= '0;
            end else begin
                busy_cnt <= busy_cnt + 1'b1;
            end
        end
    end

    // Data phase goes straight to the stages that register it
    assign wr.strobe  = data_wr;
    assign wr.sel_reg = sel_reg;
    assign wr.part    = part;
    assign wr.data    = din;

endmodule

// File: fm_global_regs.sv
/*
 * FM register block execute stage
 * Holds the timer, LFO, test, mode and DAC/PCM registers
 */

`timescale 1ns/100ps

module fm_global_regs #(
    parameter bit use_pcm = 1'b1
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,
    input  fm_mmr_pkg::data_wr_t    wr,
    input  logic                    write,
    output fm_mmr_pkg::timer_cfg_t  timer,
    output fm_mmr_pkg::chip_mode_t  mode,
    output fm_mmr_pkg::pcm_out_t    pcm
);

    fm_mmr_pkg::reg_data_t d;
    logic                  idle_cen;

    assign d        = wr.data;
    assign idle_cen = cen && !write;   // Ends the one-shot bits

    always_ff @(posedge clk) begin
        if (rst) begin
            timer <= '0;
            mode  <= '0;
        end else if (wr.strobe) begin
            case (wr.sel_reg)
                fm_mmr_pkg::reg_testym: begin
                    mode.eg_stop     <= d[5];
                    mode.pg_stop     <= d[3];
                    mode.fast_timers <= d[2];
                end
                fm_mmr_pkg::reg_lfo: begin
                    mode.lfo_en   <= d[3];
                    mode.lfo_freq <= d[2:0];
                end
                fm_mmr_pkg::reg_clka1: timer.value_a[9:2] <= d;        // High eight bits
                fm_mmr_pkg::reg_clka2: timer.value_a[1:0] <= d[1:0];   // Low two bits
                fm_mmr_pkg::reg_clkb:  timer.value_b      <= d;
                fm_mmr_pkg::reg_timer: begin
                    mode.effect <= |d[7:6];
                    mode.csm    <= d[7:6] == 2'b10;
                    {timer.clr_flag_b, timer.clr_flag_a,
                     timer.enable_irq_b, timer.enable_irq_a,
                     timer.load_b, timer.load_a} <= d[5:0];
                end
                default: ;
            endcase
        end else if (idle_cen) begin
            timer.clr_flag_a <= 1'b0;
            timer.clr_flag_b <= 1'b0;
        end
    end

    // DAC sample path
    always_ff @(posedge clk) begin
        if (rst) begin
            pcm <= '0;
        end else if (use_pcm) begin
            if (wr.strobe) begin
                case (wr.sel_reg)
                    fm_mmr_pkg::reg_pcm: begin
                        pcm.sample <= {~d[7], d[6:0], 1'b1};   // Offset binary to signed
                    end
                    fm_mmr_pkg::reg_dactest: pcm.sample[0] <= d[3];
                    fm_mmr_pkg::reg_pcm_en:  pcm.en        <= d[7];
                    default: ;
                endcase
                pcm.wr <= wr.sel_reg == fm_mmr_pkg::reg_pcm;
            end else if (idle_cen) begin
                pcm.wr <= 1'b0;
            end
        end
    end

endmodule

// File: fm_update_strobes.sv
/*
 * FM register block result stage
 * Turns each data write into the slot update selects and data byte
 * for the external channel register file
 */

`timescale 1ns/100ps

module fm_update_strobes (
    input  logic                    clk,
    input  logic                    rst,
    input  fm_mmr_pkg::data_wr_t    wr,
    output fm_mmr_pkg::reg_update_t upd
);

    fm_mmr_pkg::reg_addr_t r;

    assign r = wr.sel_reg;

    // Selects are levels, held until the next data write
    always_ff @(posedge clk) begin
        if (rst) begin
            upd <= '0;
        end else if (wr.strobe) begin
            upd.data  <= wr.data;
            upd.ch    <= {wr.part, r[1:0]};
            upd.op    <= r[3:2];
            upd.keyon <= r == fm_mmr_pkg::reg_kon;
            if (r[1:0] == 2'b11) begin
                // No channel lives at offset 3
                upd.chreg <= 3'b000;
                upd.opreg <= 7'h00;
            end else begin
                casez (r)
                    // Channel registers
                    8'hA0, 8'hA1, 8'hA2: begin
                        upd.chreg <= 3'b001;   // fnum low
                        upd.opreg <= 7'h00;
                    end
                    8'hB0, 8'hB1, 8'hB2: begin
                        upd.chreg <= 3'b010;   // FB and algorithm
                        upd.opreg <= 7'h00;
                    end
                    8'hB4, 8'hB5, 8'hB6: begin
                        upd.chreg <= 3'b100;   // pms
                        upd.opreg <= 7'h00;
                    end
                    // Operator registers, one group per bit
                    8'h3?: {upd.chreg, upd.opreg} <= {3'b000, 7'h01};   // dt1
                    8'h4?: {upd.chreg, upd.opreg} <= {3'b000, 7'h02};   // tl
                    8'h5?: {upd.chreg, upd.opreg} <= {3'b000, 7'h04};   // ks_ar
                    8'h6?: {upd.chreg, upd.opreg} <= {3'b000, 7'h08};   // amen_dr
                    8'h7?: {upd.chreg, upd.opreg} <= {3'b000, 7'h10};   // sr
                    8'h8?: {upd.chreg, upd.opreg} <= {3'b000, 7'h20};   // sl_rr
                    8'h9?: {upd.chreg, upd.opreg} <= {3'b000, 7'h40};   // ssgeg
                    default: begin
                        upd.chreg <= 3'b000;
                        upd.opreg <= 7'h00;
                    end
                endcase
            end
        end
    end

endmodule

// File: fm_mmr.sv
/*
 * FM sound chip register block, write side
 * Decode, execute and result stages behind the host bus
 */

`timescale 1ns/100ps

module fm_mmr #(
    parameter bit use_pcm  = 1'b1,
    parameter int busy_len = 32
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,
    input  fm_mmr_pkg::reg_data_t   din,
    input  logic                    write,
    input  logic [1:0]              addr,
    output logic                    busy,
    output fm_mmr_pkg::timer_cfg_t  timer,
    output fm_mmr_pkg::chip_mode_t  mode,
    output fm_mmr_pkg::pcm_out_t    pcm,
    output fm_mmr_pkg::reg_update_t upd
);

    fm_mmr_pkg::data_wr_t wr;

    fm_write_decode #(
        .busy_len (busy_len)
    ) i_decode (
        .clk   (clk),
        .rst   (rst),
        .cen   (cen),
        .din   (din),
        .write (write),
        .addr  (addr),
        .wr    (wr),
        .busy  (busy)
    );

    fm_global_regs #(
        .use_pcm (use_pcm)
    ) i_global (
        .clk   (clk),
        .rst   (rst),
        .cen   (cen),
        .wr    (wr),
        .write (write),
        .timer (timer),
        .mode  (mode),
        .pcm   (pcm)
    );

    fm_update_strobes i_update (
        .clk (clk),
        .rst (rst),
        .wr  (wr),
        .upd (upd)
    );

endmodule

// File: fm_mmr_properties.sv
/*
 * FM register block assertions
 * Strobe, select and busy rules, bound to the top level
 */

`timescale 1ns/100ps

module fm_mmr_properties (
    input logic                    clk,
    input logic                    rst,
    input logic                    cen,
    input logic                    write,
    input logic [1:0]              addr,
    input logic                    busy,
    input fm_mmr_pkg::pcm_out_t    pcm,
    input fm_mmr_pkg::reg_update_t upd
);

    int fail_count = 0;

    // An idle cen ends the DAC write strobe
    pcm_wr_ends: assert property (@(posedge clk) disable iff (rst)
        cen && !write |=> !pcm.wr)
        else begin
            fail_count++;
            $error("pcm wr still high after an idle cen");
        end

    one_select: assert property (@(posedge clk) disable iff (rst)
        $onehot0({upd.chreg, upd.opreg}))   // Never two slots at once
        else begin
            fail_count++;
            $error("more than one chreg or opreg select is set");
        end

    // Low after reset, and only a data write raises it
    busy_after_reset: assert property (@(posedge clk)
        rst || (!busy && !(write && addr[0])) |=> !busy)
        else begin
            fail_count++;
            $error("busy is high after reset or without a data write");
        end

endmodule

// File: fm_mmr_checker.sv
/*
 * FM register block checker
 * Compares DUT outputs with the expected values from the driver,
 * follows the one-shot bits and the busy length, and counts errors
 */

`timescale 1ns/100ps

module fm_mmr_checker #(
    parameter int busy_len = 32
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,
    input  logic                    write,
    input  logic                    busy,
    input  fm_mmr_pkg::timer_cfg_t  timer,
    input  fm_mmr_pkg::chip_mode_t  mode,
    input  fm_mmr_pkg::pcm_out_t    pcm,
    input  fm_mmr_pkg::reg_update_t upd,
    input  logic                    check,
    input  string                   exp_name,
    input  string                   exp_field,
    input  logic [15:0]             exp_value,
    input  fm_mmr_pkg::reg_data_t   exp_data,
    output int                      checks,
    output int                      errors
);

    logic  rst_q;
    logic  tracking;     // Counting cen pulses while busy
    logic  clear_wait;   // One-shot set and waiting for an idle cen
    logic  clear_due;    // One-shot must read 0 in this cycle
    int    cen_seen;
    string shot_name;
    string shot_field;

    initial begin
        checks     = 0;
        errors     = 0;
        tracking   = 1'b0;
        clear_wait = 1'b0;
        clear_due  = 1'b0;
    end

    function automatic logic [15:0] field_value(input string f);
        case (f)
            "value_a":    return 16'(timer.value_a);
            "value_b":    return 16'(timer.value_b);
            "ctrl":       return 16'({timer.clr_flag_b, timer.clr_flag_a, timer.enable_irq_b,
                                      timer.enable_irq_a, timer.load_b, timer.load_a});
            "clr_flag":   return 16'({timer.clr_flag_b, timer.clr_flag_a});
            "csm_effect": return 16'({mode.csm, mode.effect});
            "lfo":        return 16'({mode.lfo_en, mode.lfo_freq});
            "test":       return 16'({mode.eg_stop, mode.pg_stop, mode.fast_timers});
            "pcm_sample": return 16'(pcm.sample);
            "pcm_en":     return 16'(pcm.en);
            "pcm_wr":     return 16'(pcm.wr);
            "opreg":      return 16'(upd.opreg);
            "chreg":      return 16'(upd.chreg);
            "selects":    return 16'({upd.chreg, upd.opreg});
            "ch":         return 16'(upd.ch);
            "op":         return 16'(upd.op);
            "keyon":      return 16'(upd.keyon);
            default:      return 16'hxxxx;   // Unknown name shows up as a mismatch
        endcase
    endfunction

    task automatic compare(input string name, input string what,
                           input logic [15:0] expected, input logic [15:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s: %s expected %h actual %h", name, what, expected, actual);
        end
    endtask

    always @(posedge clk) begin
        rst_q <= rst;
        if (rst) begin
            tracking   = 1'b0;
            clear_wait = 1'b0;
            clear_due  = 1'b0;
        end else begin
            if (rst_q) begin
                compare("reset_state", "outputs", 16'h0000,
                        16'(|{timer, mode, pcm, upd}));
                compare("reset_state", "busy", 16'h0000, 16'(busy));
            end
            if (clear_due) begin
                compare(shot_name, shot_field, 16'h0000, field_value(shot_field));
                clear_due = 1'b0;
            end else if (clear_wait && cen && !write) begin
                clear_due  = 1'b1;
                clear_wait = 1'b0;
            end
            if (check) begin
                compare(exp_name, exp_field, exp_value, field_value(exp_field));
                compare(exp_name, "upd_data", 16'(exp_data), 16'(upd.data));
                compare(exp_name, "busy", 16'h0001, 16'(busy));
                tracking = 1'b1;
                cen_seen = cen ? 1 : 0;
                if ((exp_field == "clr_flag" || exp_field == "pcm_wr") && exp_value != 0) begin
                    shot_name  = exp_name;
                    shot_field = exp_field;
                    if (cen && !write) clear_due = 1'b1;
                    else clear_wait = 1'b1;
                end
            end else if (tracking) begin
                if (cen_seen < busy_len) begin
                    if (!busy) begin
                        errors++;
                        $display("busy in test %s fell after only %0d cen pulses",
                                 exp_name, cen_seen);
                        tracking = 1'b0;
                    end else if (cen) begin
                        cen_seen++;
                    end
                end else begin
                    checks++;
                    if (busy) begin
                        errors++;
                        $display("busy in test %s still high after %0d cen pulses",
                                 exp_name, cen_seen);
                    end
                    tracking = 1'b0;
                end
            end
        end
    end

endmodule

// File: tb_fm_mmr.sv
/*
 * FM register block testbench
 * Clock, reset, a stimulus table of register writes and the timeout
 */

`timescale 1ns/100ps

module tb_fm_mmr;

    localparam int busy_len = 32;

    typedef struct {
        string                 name;
        logic                  part;
        fm_mmr_pkg::reg_addr_t reg_num;
        fm_mmr_pkg::reg_data_t data;
        string                 field;   // Output field checked after the write
        logic [15:0]           value;
    } entry_t;

    entry_t tests[$];

    logic                    clk;
    logic                    rst;
    logic                    cen;
    logic [1:0]              cen_phase;
    fm_mmr_pkg::reg_data_t   din;
    logic                    write;
    logic [1:0]              addr;
    logic                    busy;
    fm_mmr_pkg::timer_cfg_t  timer;
    fm_mmr_pkg::chip_mode_t  mode;
    fm_mmr_pkg::pcm_out_t    pcm;
    fm_mmr_pkg::reg_update_t upd;
    logic                    check;
    string                   exp_name;
    string                   exp_field;
    logic [15:0]             exp_value;
    fm_mmr_pkg::reg_data_t   exp_data;
    int                      checks;
    int                      errors;
    int                      cycles;
    int                      cycle_limit;

    fm_mmr #(
        .use_pcm  (1'b1),
        .busy_len (busy_len)
    ) i_dut (
        .clk   (clk),
        .rst   (rst),
        .cen   (cen),
        .din   (din),
        .write (write),
        .addr  (addr),
        .busy  (busy),
        .timer (timer),
        .mode  (mode),
        .pcm   (pcm),
        .upd   (upd)
    );

    bind fm_mmr fm_mmr_properties i_props (.*);

    fm_mmr_checker #(
        .busy_len (busy_len)
    ) i_checker (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .write     (write),
        .busy      (busy),
        .timer     (timer),
        .mode      (mode),
        .pcm       (pcm),
        .upd       (upd),
        .check     (check),
        .exp_name  (exp_name),
        .exp_field (exp_field),
        .exp_value (exp_value),
        .exp_data  (exp_data),
        .checks    (checks),
        .errors    (errors)
    );

    task automatic add_test(input string name, input logic part,
                            input fm_mmr_pkg::reg_addr_t r, input fm_mmr_pkg::reg_data_t d,
                            input string field, input logic [15:0] value);
        entry_t e;
        e.name    = name;
        e.part    = part;
        e.reg_num = r;
        e.data    = d;
        e.field   = field;
        e.value   = value;
        tests.push_back(e);
    endtask

    task automatic load_table();
        add_test("clka1_high",   1'b0, 8'h24, 8'hA5, "value_a",    16'h0294);
        add_test("clka2_low",    1'b0, 8'h25, 8'h03, "value_a",    16'h0297);
        add_test("clka2_mask",   1'b0, 8'h25, 8'hFE, "value_a",    16'h0296);
        add_test("clkb",         1'b0, 8'h26, 8'h3C, "value_b",    16'h003C);
        add_test("timer_ctrl",   1'b0, 8'h27, 8'h0F, "ctrl",       16'h000F);
        add_test("timer_csm",    1'b0, 8'h27, 8'h85, "csm_effect", 16'h0003);
        add_test("timer_effect", 1'b0, 8'h27, 8'hC0, "csm_effect", 16'h0001);
        add_test("flag_clear",   1'b0, 8'h27, 8'h30, "clr_flag",   16'h0003);
        add_test("lfo_on",       1'b0, 8'h22, 8'h0D, "lfo",        16'h000D);
        add_test("lfo_off",      1'b0, 8'h22, 8'h03, "lfo",        16'h0003);
        add_test("test_all",     1'b0, 8'h21, 8'h2C, "test",       16'h0007);
        add_test("test_pg",      1'b0, 8'h21, 8'h08, "test",       16'h0002);
        add_test("pcm_sample",   1'b0, 8'h2A, 8'h5A, "pcm_sample", 16'h01B5);
        add_test("pcm_strobe",   1'b0, 8'h2A, 8'h5A, "pcm_wr",     16'h0001);
        add_test("dac_test",     1'b0, 8'h2C, 8'h00, "pcm_sample", 16'h01B4);
        add_test("pcm_enable",   1'b0, 8'h2B, 8'h80, "pcm_en",     16'h0001);
        add_test("pcm_negative", 1'b0, 8'h2A, 8'hC3, "pcm_sample", 16'h0087);
        add_test("op_select",    1'b1, 8'h52, 8'h1F, "opreg",      16'h0004);
        add_test("op_channel",   1'b1, 8'h52, 8'h1F, "ch",         16'h0006);
        add_test("op_slot",      1'b1, 8'h52, 8'h1F, "op",         16'h0000);
        add_test("fnum_low",     1'b0, 8'hA1, 8'h22, "chreg",      16'h0001);
        add_test("pms",          1'b0, 8'hB5, 8'hC0, "chreg",      16'h0004);
        add_test("no_slot",      1'b0, 8'h93, 8'h0F, "selects",    16'h0000);
        add_test("key_on",       1'b0, 8'h28, 8'hF1, "keyon",      16'h0001);
    endtask

    // Address write, data write, then idle until busy drops
    task automatic apply_test(input entry_t t);
        write <= 1'b1;
        addr  <= {t.part, 1'b0};
        din   <= t.reg_num;
        @(posedge clk);
        addr  <= {t.part, 1'b1};
        din   <= t.data;
        @(posedge clk);
        write     <= 1'b0;
        check     <= 1'b1;
        exp_name  <= t.name;
        exp_field <= t.field;
        exp_value <= t.value;
        exp_data  <= t.data;
        @(posedge clk);
        check <= 1'b0;
        while (busy) @(posedge clk);
    endtask

    task automatic end_run(input logic timed_out);
        int prop_fails;
        prop_fails = i_dut.i_props.fail_count;
        $display("checks: %0d  errors: %0d  assertion failures: %0d",
                 checks, errors, prop_fails);
        if (timed_out || errors != 0 || prop_fails != 0) begin
            $display("Simulation failed");
        end else begin
            $display("Simulation completed successfully");
        end
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // cen on every fourth clock
    always @(posedge clk) begin
        cen_phase <= cen_phase + 1'b1;
        cen       <= cen_phase == 2'd2;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
            end_run(1'b1);
        end
    end

    initial begin
        rst       = 1'b1;
        cen       = 1'b0;
        cen_phase = 2'd0;
        din       = '0;
        write     = 1'b0;
        addr      = 2'b00;
        check     = 1'b0;
        exp_name  = "";
        exp_field = "";
        exp_value = '0;
        exp_data  = '0;
        cycles    = 0;
        load_table();
        cycle_limit = tests.size() * (2 + 4 * busy_len + 4) + 50;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        foreach (tests[i]) begin
            apply_test(tests[i]);
        end
        @(posedge clk);
        end_run(1'b0);
    end

endmodule

// File: project.f
fm_mmr_pkg.sv
fm_write_decode.sv
fm_global_regs.sv
fm_update_strobes.sv
fm_mmr.sv
fm_mmr_properties.sv
fm_mmr_checker.sv
tb_fm_mmr.sv

// File: Bender.yml
package:
  name: fm_mmr

sources:
  - fm_mmr_pkg.sv
  - fm_write_decode.sv
  - fm_global_regs.sv
  - fm_update_strobes.sv
  - fm_mmr.sv
  - target: test
    files:
      - fm_mmr_properties.sv
      - fm_mmr_checker.sv
      - tb_fm_mmr.sv
